/* files.f */
src/iter_pkg.sv
src/sample_stepper.sv
src/iter_fsm.sv
src/bbox_iterator.sv
sim/tb_clock.sv
sim/bbox_iterator_tb.sv

/* Makefile */
# Verilator build and run of the bounding-box iterator testbench
# Any variable below can be set on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= bbox_iterator_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
SIM_ARGS  ?=

FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	    echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
	    echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/bbox_iterator_tb.sv */
/*
 * Testbench for the bounding-box sample iterator.
 * Feeds LFSR-made triangles at all four MSAA rates, keeps its own scan model
 * and checks samples, walk length, hold and payload with concurrent assertions.
 */

`timescale 1ns/1ns

module bbox_iterator_tb
    import iter_pkg::*;
();

    localparam int period     = 100;
    localparam int drive_dly  = 10;            // Inputs change this long after the edge
    localparam int grid_lsb   = DEF_RADIX - 3; // Eighth-pixel bit
    localparam int n_random   = 24;
    localparam int n_tri      = 16 + n_random; // Four shapes at four rates, then random
    localparam int max_walk   = 6 * 3;         // 6 columns by 3 row groups
    localparam int margin     = 8;             // Bubble and rate changes per triangle
    localparam int shape_cols [4] = '{1, 5, 1, 4};
    localparam int shape_rows [4] = '{1, 1, 7, 7}; // 1x1, one row, one column, 3 groups

    typedef logic signed [DEF_SIGFIG-1:0] coord_t;
    typedef logic        [DEF_SIGFIG-1:0] word_t;

    logic       clk;
    logic       rst;
    coord_t     tri_in    [DEF_VERTS-1:0][DEF_AXIS-1:0];
    word_t      color_in  [DEF_COLORS-1:0];
    coord_t     box_in    [1:0][1:0];
    logic       valid_tri;
    msaa_rate_t rate;
    coord_t     tri_out   [DEF_VERTS-1:0][DEF_AXIS-1:0];
    word_t      color_out [DEF_COLORS-1:0];
    coord_t     sample_a  [1:0];
    coord_t     sample_b  [1:0];
    coord_t     sample_c  [1:0];
    logic       valid_samp;
    logic       hold;

    // Scan model, one cycle behind the inputs like the DUT
    coord_t      m_tri   [DEF_VERTS-1:0][DEF_AXIS-1:0];
    word_t       m_color [DEF_COLORS-1:0];
    coord_t      m_left;
    coord_t      m_right;
    coord_t      m_x;     // Expected row a
    coord_t      m_y;
    coord_t      m_step;
    int          m_cnt;   // Valid cycles left, this one included
    logic        m_active;
    logic [31:0] lfsr_state = 32'h5b6a8455;
    int          value_errs = 0;
    int          proto_errs = 0;

    tb_clock #(.period(period), .reset_cycles(2)) i_clock (.clk(clk), .rst(rst));

    bbox_iterator i_dut (
        .clk        (clk),
        .rst        (rst),
        .tri_in     (tri_in),
        .color_in   (color_in),
        .box_in     (box_in),
        .valid_tri  (valid_tri),
        .rate       (rate),
        .tri_out    (tri_out),
        .color_out  (color_out),
        .sample_a   (sample_a),
        .sample_b   (sample_b),
        .sample_c   (sample_c),
        .valid_samp (valid_samp),
        .hold       (hold)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // One step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Rate code read as a number is the step in eighths of a pixel
    function automatic coord_t grid_step(input msaa_rate_t r);
        return coord_t'(r) << grid_lsb;
    endfunction

    function automatic int walk_cycles(input coord_t left, right, bottom, top, s);
        int cols;
        int rows;
        cols = int'((right - left) / s) + 1;
        rows = int'((top - bottom) / s) + 1;
        return cols * ((rows + ROWS_PER_STEP - 1) / ROWS_PER_STEP);
    endfunction

    task automatic value_error(input string name, input word_t exp, input word_t act);
        value_errs++;
        $display("error %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
    endtask

    task automatic protocol_error(input string what);
        proto_errs++;
        $display("protocol failure at %0t: %s", $time, what);
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #drive_dly;
    endtask

    task automatic scramble_payload();
        foreach (tri_in[v, a]) begin
            tri_in[v][a] = coord_t'(draw(DEF_SIGFIG));
        end
        foreach (color_in[c]) begin
            color_in[c] = word_t'(draw(DEF_SIGFIG));
        end
    endtask

    // Grid-aligned box with its lower-left corner near the origin
    task automatic load_triangle(input int cols, input int rows, input msaa_rate_t r);
        coord_t s;
        coord_t x0;
        coord_t y0;
        s  = grid_step(r);
        x0 = (coord_t'(draw(8)) - coord_t'(128)) * s;
        y0 = (coord_t'(draw(8)) - coord_t'(128)) * s;
        box_in[0][0] = x0;
        box_in[0][1] = y0;
        box_in[1][0] = x0 + coord_t'(cols - 1) * s;
        box_in[1][1] = y0 + coord_t'(rows - 1) * s;
        scramble_payload();
    endtask

    // Offer one triangle and return once it has been taken
    task automatic offer_tri(input msaa_rate_t r, input int cols, input int rows,
                             input logic churn);
        logic free;
        if (r != rate) begin
            while (hold) begin
                step_cycle(); // Rate only moves while idle
            end
            rate = r;
        end
        load_triangle(cols, rows, r);
        valid_tri = 1'b1;
        do begin
            free = !hold; // Holds until the next edge
            step_cycle();
        end while (!free);
        valid_tri = 1'b0;
        while (churn && hold) begin
            scramble_payload(); // Payload out must not follow these
            step_cycle();
        end
    endtask

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_active <= 1'b0;
            m_cnt    <= 0;
        end else if (valid_tri && !hold) begin
            m_tri    <= tri_in;
            m_color  <= color_in;
            m_left   <= box_in[0][0];
            m_right  <= box_in[1][0];
            m_x      <= box_in[0][0]; // First triple at the lower-left corner
            m_y      <= box_in[0][1];
            m_step   <= grid_step(rate);
            m_cnt    <= walk_cycles(box_in[0][0], box_in[1][0], box_in[0][1],
                                    box_in[1][1], grid_step(rate));
            m_active <= 1'b1;
        end else if (m_active) begin
            if (m_x == m_right) begin
                m_x <= m_left;
                m_y <= m_y + coord_t'(ROWS_PER_STEP) * m_step; // Next row group
            end else begin
                m_x <= m_x + m_step;
            end
            m_cnt    <= m_cnt - 1;
            m_active <= (m_cnt > 1);
        end
    end

    reset_quiet: assert property (@(posedge clk) rst |-> !valid_samp && !hold)
        else protocol_error("valid_samp or hold high during reset");
    walk_valid: assert property (@(posedge clk) disable iff (rst) valid_samp == m_active)
        else value_error("walk_valid", word_t'($sampled(m_active)), word_t'($sampled(valid_samp)));
    walk_hold: assert property (@(posedge clk) disable iff (rst) hold == m_active)
        else value_error("walk_hold", word_t'($sampled(m_active)), word_t'($sampled(hold)));
    one_bubble: assert property (@(posedge clk) disable iff (rst)
        $fell(hold) && valid_tri |=> hold)
        else protocol_error("waiting triangle not taken on the first idle edge");

    scan_a_x: assert property (@(posedge clk) disable iff (rst)
        valid_samp |-> sample_a[0] == m_x)
        else value_error("scan_a_x", $sampled(m_x), $sampled(sample_a[0]));
    scan_a_y: assert property (@(posedge clk) disable iff (rst)
        valid_samp |-> sample_a[1] == m_y)
        else value_error("scan_a_y", $sampled(m_y), $sampled(sample_a[1]));
    scan_b_x: assert property (@(posedge clk) disable iff (rst)
        valid_samp |-> sample_b[0] == m_x)
        else value_error("scan_b_x", $sampled(m_x), $sampled(sample_b[0]));
    scan_b_y: assert property (@(posedge clk) disable iff (rst)
        valid_samp |-> sample_b[1] == m_y + m_step)
        else value_error("scan_b_y", $sampled(m_y + m_step), $sampled(sample_b[1]));
    scan_c_x: assert property (@(posedge clk) disable iff (rst)
        valid_samp |-> sample_c[0] == m_x)
        else value_error("scan_c_x", $sampled(m_x), $sampled(sample_c[0]));
    scan_c_y: assert property (@(posedge clk) disable iff (rst)
        valid_samp |-> sample_c[1] == m_y + m_step + m_step)
        else value_error("scan_c_y", $sampled(m_y + m_step + m_step), $sampled(sample_c[1]));
    on_grid: assert property (@(posedge clk) disable iff (rst)
        valid_samp |-> sample_a[0][grid_lsb-1:0] == '0 && sample_a[1][grid_lsb-1:0] == '0
                    && sample_b[1][grid_lsb-1:0] == '0 && sample_c[1][grid_lsb-1:0] == '0)
        else protocol_error("sample bits below the grid step are not zero");

    // Payload held for the whole walk, element by element
    for (genvar v = 0; v < DEF_VERTS; v++) begin : g_vert
        for (genvar a = 0; a < DEF_AXIS; a++) begin : g_axis
            payload_tri: assert property (@(posedge clk) disable iff (rst)
                valid_samp |-> tri_out[v][a] == m_tri[v][a])
                else value_error("payload_tri", $sampled(m_tri[v][a]), $sampled(tri_out[v][a]));
        end
    end
    for (genvar c = 0; c < DEF_COLORS; c++) begin : g_color
        payload_color: assert property (@(posedge clk) disable iff (rst)
            valid_samp |-> color_out[c] == m_color[c])
            else value_error("payload_color", $sampled(m_color[c]), $sampled(color_out[c]));
    end

    initial begin
        msaa_rate_t r;
        int         cols;
        int         rows;
        logic       churn;
        valid_tri = 1'b0;
        rate      = MSAA_1X;
        foreach (box_in[i, j]) begin
            box_in[i][j] = '0;
        end
        scramble_payload();
        @(negedge rst);
        repeat (3) step_cycle(); // Idle after reset, nothing may rise
        for (int k = 0; k < 16; k++) begin
            r = msaa_rate_t'(4'b1000 >> (k / 4)); // Every shape at every rate
            offer_tri(r, shape_cols[k % 4], shape_rows[k % 4], (k % 2) == 1);
        end
        for (int n = 0; n < n_random; n++) begin
            r     = msaa_rate_t'(4'b0001 << draw(2));
            cols  = 1 + int'(draw(8) % 6);
            rows  = 1 + int'(draw(8) % 7);
            churn = (draw(1) == 32'd1);
            offer_tri(r, cols, rows, churn);
        end
        while (hold || valid_samp) begin
            step_cycle();
        end
        repeat (3) step_cycle();
        $display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Worst case every triangle walks the largest box
    initial begin
        #((n_tri * (max_walk + margin) + 20) * period);
        $display("watchdog expired, the run did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
/*
 * Clock and power-on reset for the iterator testbench.
 * Reset is held for a set number of rising edges, then released off the edge.
 */

`timescale 1ns/1ns

module tb_clock #(
    parameter int period       = 100, // Clock period in ns
    parameter int reset_cycles = 2    // Rising edges seen with rst high
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #(period / 10) rst = 1'b0; // Same offset as the other inputs
    end

endmodule

/* src/bbox_iterator.sv */
/*
 * Bounding-box sample iterator, top level.
 * Walks a triangle's box on the MSAA grid three rows at a time and holds
 * upstream with hold until the walk is over. Joins the stepper datapath
 * and the controller.
 */

`timescale 1ns/1ns

module bbox_iterator
    import iter_pkg::*;
#(
    parameter int sig_fig = DEF_SIGFIG, // Coordinate and colour width
    parameter int radix   = DEF_RADIX,  // Fraction bits
    parameter int verts   = DEF_VERTS,
    parameter int axis    = DEF_AXIS,
    parameter int colors  = DEF_COLORS
) (
    input  logic                      clk,
    input  logic                      rst,
    // Upstream
    input  logic signed [sig_fig-1:0] tri_in    [verts-1:0][axis-1:0],
    input  logic        [sig_fig-1:0] color_in  [colors-1:0],
    input  logic signed [sig_fig-1:0] box_in    [1:0][1:0], // Grid-aligned corners
    input  logic                      valid_tri,
    input  msaa_rate_t                rate,                 // Stable during a walk
    // Downstream
    output logic signed [sig_fig-1:0] tri_out   [verts-1:0][axis-1:0],
    output logic        [sig_fig-1:0] color_out [colors-1:0],
    output logic signed [sig_fig-1:0] sample_a  [1:0],     // Row y
    output logic signed [sig_fig-1:0] sample_b  [1:0],     // Row y+s
    output logic signed [sig_fig-1:0] sample_c  [1:0],     // Row y+2s
    output logic                      valid_samp,
    output logic                      hold
);

    // Stepper to controller
    logic signed [sig_fig-1:0] start_a [1:0];
    logic signed [sig_fig-1:0] start_b [1:0];
    logic signed [sig_fig-1:0] start_c [1:0];
    logic signed [sig_fig-1:0] next_a  [1:0];
    logic signed [sig_fig-1:0] next_b  [1:0];
    logic signed [sig_fig-1:0] next_c  [1:0];
    logic                      at_end;
    // Controller to stepper
    logic signed [sig_fig-1:0] box     [1:0][1:0];
    iter_state_t               fsm_state;

    sample_stepper #(
        .sig_fig (sig_fig),
        .radix   (radix)
    ) i_stepper (
        .sample_a (sample_a),
        .sample_b (sample_b),
        .sample_c (sample_c),
        .box      (box),
        .box_in   (box_in),
        .rate     (rate),
        .start_a  (start_a),
        .start_b  (start_b),
        .start_c  (start_c),
        .next_a   (next_a),
        .next_b   (next_b),
        .next_c   (next_c),
        .at_end   (at_end)
    );

    iter_fsm #(
        .sig_fig (sig_fig),
        .radix   (radix),
        .verts   (verts),
        .axis    (axis),
        .colors  (colors)
    ) i_fsm (
        .clk        (clk),
        .rst        (rst),
        .valid_tri  (valid_tri),
        .tri_in     (tri_in),
        .color_in   (color_in),
        .box_in     (box_in),
        .start_a    (start_a),
        .start_b    (start_b),
        .start_c    (start_c),
        .next_a     (next_a),
        .next_b     (next_b),
        .next_c     (next_c),
        .at_end     (at_end),
        .state      (fsm_state),
        .box        (box),
        .sample_a   (sample_a),
        .sample_b   (sample_b),
        .sample_c   (sample_c),
        .tri_out    (tri_out),
        .color_out  (color_out),
        .valid_samp (valid_samp),
        .hold       (hold)
    );

    // Step size must not move under a walk in progress
    rate_stable: assert property (
        @(posedge clk) disable iff (rst)
        (fsm_state == TEST_ST) |-> $stable(rate)
    ) else $error("MSAA rate changed during a box walk");

endmodule

/* src/iter_fsm.sv */
/*
 * Wait/test controller of the box iterator.
 * Takes a triangle on valid_tri while idle, holds upstream with hold and
 * steps the three sample rows every cycle until the stepper flags the end.
 * All outputs are registered, one cycle after the inputs they follow.
 */

`timescale 1ns/1ns

module iter_fsm
    import iter_pkg::*;
#(
    parameter int sig_fig = 24, // Coordinate and colour width
    parameter int radix   = 10, // Fraction bits
    parameter int verts   = 3,  // Vertices per triangle
    parameter int axis    = 3,  // Axes per vertex
    parameter int colors  = 3   // Colour channels
) (
    input  logic                      clk,
    input  logic                      rst,
    // Upstream triangle
    input  logic                      valid_tri,
    input  logic signed [sig_fig-1:0] tri_in    [verts-1:0][axis-1:0],
    input  logic        [sig_fig-1:0] color_in  [colors-1:0],
    input  logic signed [sig_fig-1:0] box_in    [1:0][1:0],
    // From the stepper
    input  logic signed [sig_fig-1:0] start_a   [1:0],
    input  logic signed [sig_fig-1:0] start_b   [1:0],
    input  logic signed [sig_fig-1:0] start_c   [1:0],
    input  logic signed [sig_fig-1:0] next_a    [1:0],
    input  logic signed [sig_fig-1:0] next_b    [1:0],
    input  logic signed [sig_fig-1:0] next_c    [1:0],
    input  logic                      at_end,
    // Registered state and walk position
    output iter_state_t               state,
    output logic signed [sig_fig-1:0] box       [1:0][1:0],
    output logic signed [sig_fig-1:0] sample_a  [1:0],
    output logic signed [sig_fig-1:0] sample_b  [1:0],
    output logic signed [sig_fig-1:0] sample_c  [1:0],
    // Payload to the sample test
    output logic signed [sig_fig-1:0] tri_out   [verts-1:0][axis-1:0],
    output logic        [sig_fig-1:0] color_out [colors-1:0],
    output logic                      valid_samp,
    output logic                      hold             // High while walking
);

    localparam int step_lsb = radix - 3; // Grid LSB, lower bits stay clear

    iter_state_t next_state;
    logic        take;      // Triangle consumed this edge
    logic        low_clear; // Row a has no bits below the grid

    assign take = (state == WAIT_ST) && valid_tri;

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            WAIT_ST: begin
                if (valid_tri) begin
                    next_state = TEST_ST; // Start on the lower-left corner
                end
            end
            TEST_ST: begin
                if (at_end) begin
                    next_state = WAIT_ST; // Last triple goes out this cycle
                end
            end
        endcase
    end

    // Control registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= WAIT_ST;
            valid_samp <= 1'b0;
            hold       <= 1'b0;
        end else begin
            state      <= next_state;
            valid_samp <= (next_state == TEST_ST); // A triple every walking cycle
            hold       <= (next_state == TEST_ST); // Upstream waits until idle
        end
    end

    // Box, samples and payload
    always_ff @(posedge clk) begin
        if (take) begin
            tri_out   <= tri_in;
            color_out <= color_in;
            box       <= box_in;
            sample_a  <= start_a;
            sample_b  <= start_b;
            sample_c  <= start_c;
        end else if (state == TEST_ST) begin
            // Payload and box stay put for the whole walk
            sample_a  <= next_a;
            sample_b  <= next_b;
            sample_c  <= next_c;
        end
    end

    // Grid check on row a
    always_comb begin
        low_clear = (sample_a[0][step_lsb-1:0] == '0)
                  && (sample_a[1][step_lsb-1:0] == '0);
    end

    // A taken triangle starts the walk
    take_starts_walk: assert property (
        @(posedge clk) disable iff (rst)
        take |=> (state == TEST_ST) && valid_samp && hold
    ) else $error("triangle taken but walk did not start");

    // End of box returns to idle
    end_stops_walk: assert property (
        @(posedge clk) disable iff (rst)
        (state == TEST_ST && at_end) |=> (state == WAIT_ST) && !valid_samp && !hold
    ) else $error("end of box seen but walk did not stop");

    // No other case changes the state
    state_holds: assert property (
        @(posedge clk) disable iff (rst)
        !take && !(state == TEST_ST && at_end) |=> $stable(state)
    ) else $error("controller changed state without cause");

    // Row a stays inside the held box and on the grid
    sample_in_box: assert property (
        @(posedge clk) disable iff (rst)
        valid_samp |-> (sample_a[0] >= box[0][0]) && (sample_a[0] <= box[1][0])
                    && (sample_a[1] >= box[0][1]) && (sample_a[1] <= box[1][1])
                    && low_clear
    ) else $error("row a sample outside the box or off the grid");

    // Rows b and c ride on row a's column
    rows_share_x: assert property (
        @(posedge clk) disable iff (rst)
        valid_samp |-> (sample_b[0] == sample_a[0]) && (sample_c[0] == sample_a[0])
    ) else $error("sample rows b and c left row a's column");

endmodule

/* src/sample_stepper.sv */
/*
 * Next-sample datapath for the three-row box walk.
 * Purely combinational. The controller feeds in the current samples and
 * the held box, and picks between the start and stepped positions.
 * Index 0 of a sample is x, index 1 is y. Box row 0 is lower-left.
 */

`timescale 1ns/1ns

module sample_stepper
    import iter_pkg::*;
#(
    parameter int sig_fig = 24, // Coordinate width
    parameter int radix   = 10  // Fraction bits
) (
    // Current samples held by the controller
    input  logic signed [sig_fig-1:0] sample_a [1:0],
    input  logic signed [sig_fig-1:0] sample_b [1:0],
    input  logic signed [sig_fig-1:0] sample_c [1:0],
    input  logic signed [sig_fig-1:0] box      [1:0][1:0], // Held box
    input  logic signed [sig_fig-1:0] box_in   [1:0][1:0], // Incoming box
    input  msaa_rate_t                rate,
    // Positions for a freshly taken triangle
    output logic signed [sig_fig-1:0] start_a  [1:0],
    output logic signed [sig_fig-1:0] start_b  [1:0],
    output logic signed [sig_fig-1:0] start_c  [1:0],
    // Positions one walk step on
    output logic signed [sig_fig-1:0] next_a   [1:0],
    output logic signed [sig_fig-1:0] next_b   [1:0],
    output logic signed [sig_fig-1:0] next_c   [1:0],
    output logic                      at_end           // Last triple of the box
);

    localparam int step_lsb = radix - 3;          // One eighth of a pixel
    localparam int hi_w     = sig_fig - step_lsb; // Bits at or above the step LSB

    logic [hi_w-1:0] step;     // One sample step
    logic [hi_w-1:0] step_2;   // Two steps, start of row c
    logic [hi_w-1:0] step_up;  // Height of one row group
    logic            at_right; // Row a on the right edge
    logic            top_a;
    logic            top_b;
    logic            top_c;

    // Add a step count at the step LSB
    // Bits below the LSB come out zero
    function automatic logic signed [sig_fig-1:0] add_steps(
        input logic signed [sig_fig-1:0] v,
        input logic        [hi_w-1:0]    inc
    );
        logic signed [sig_fig-1:0] r;
        r = '0;
        r[sig_fig-1:step_lsb] = v[sig_fig-1:step_lsb] + inc;
        return r;
    endfunction

    // One row's next position
    function automatic void walk_row(
        input  logic signed [sig_fig-1:0] cur [1:0],
        input  logic                      up,
        output logic signed [sig_fig-1:0] nxt [1:0]
    );
        if (up) begin
            nxt[0] = box[0][0];                // Back to the left edge
            nxt[1] = add_steps(cur[1], step_up);
        end else begin
            nxt[0] = add_steps(cur[0], step);  // One step right
            nxt[1] = cur[1];                   // Same row
        end
    endfunction

    always_comb begin
        step    = hi_w'(rate);   // One-hot code is the step size
        step_2  = step + step;
        step_up = step * hi_w'(ROWS_PER_STEP);
    end

    // Edge detect, the right edge is judged on row a alone
    always_comb begin
        at_right = (sample_a[0] == box[1][0]);
        top_a    = (sample_a[1] == box[1][1]);
        top_b    = (sample_b[1] == box[1][1]);
        top_c    = (sample_c[1] == box[1][1]);
        // Rows b and c may overshoot the top in the last group
        at_end   = at_right & (top_a | top_b | top_c);
    end

    // Stepped positions
    always_comb begin
        walk_row(sample_a, at_right, next_a);
        walk_row(sample_b, at_right, next_b);
        walk_row(sample_c, at_right, next_c);
    end

    // Start positions from the incoming box
    always_comb begin
        start_a    = box_in[0];                         // Lower-left corner as is
        start_b[0] = box_in[0][0];
        start_b[1] = add_steps(box_in[0][1], step);     // One step up
        start_c[0] = box_in[0][0];
        start_c[1] = add_steps(box_in[0][1], step_2);   // Two steps up
    end

endmodule

/* src/iter_pkg.sv */
/*
 * Shared types and default sizes for the bounding-box sample iterator.
 * Modules pull these in with a wildcard import in their header.
 * Coordinates are signed fixed point with DEF_RADIX fraction bits.
 */

package iter_pkg;

    // Controller state
    typedef enum logic {
        WAIT_ST, // Idle, upstream may hand over a triangle
        TEST_ST  // Walking the held box
    } iter_state_t;

    // Sample spacing as a one-hot code
    // Read as unsigned it is the step in eighths of a pixel
    typedef enum logic [3:0] {
        MSAA_1X  = 4'b1000, // One sample per pixel
        MSAA_4X  = 4'b0100, // Half pixel grid
        MSAA_16X = 4'b0010, // Quarter pixel grid
        MSAA_64X = 4'b0001  // Eighth pixel grid
    } msaa_rate_t;

    // Fixed-point layout
    localparam int DEF_SIGFIG = 24; // Bits per coordinate or colour
    localparam int DEF_RADIX  = 10; // Fraction bits

    // Triangle shape
    localparam int DEF_VERTS  = 3;  // Vertices per triangle
    localparam int DEF_AXIS   = 3;  // x, y and z per vertex
    localparam int DEF_COLORS = 3;  // Colour channels

    // Sample rows emitted together each cycle
    // Rows a, b and c sit at y, y+s and y+2s
    localparam int ROWS_PER_STEP = 3;

endpackage
